/* hdl/core_sink.sv */
`timescale 1ns/1ns

module core_sink (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  output streamer_pkg::streamer_flags_t flags_o,
  output streamer_pkg::mem_req_t        mem_req_o,
  input  streamer_pkg::mem_rsp_t        mem_rsp_i,
  input  streamer_pkg::strm_t           snk_strm_i,
  output logic                          snk_ready_o
);

  streamer_pkg::streamer_state_t cs, ns;

  logic                            gen_en;
  logic                            gen_clr;
  logic                            gen_valid;
  logic                            gen_done;
  logic [streamer_pkg::ADDR_W-1:0] gen_addr;
  logic                            wr_acc;     // write granted
  logic [streamer_pkg::LEN_W-1:0]  wr_cnt_q;
  logic [streamer_pkg::LEN_W-1:0]  wr_cnt_d;
  logic [streamer_pkg::LEN_W-1:0]  len_q;
  logic                            job_end;

  stream_addr_gen i_addr_gen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .clear_i      ( gen_clr   ),
    .ctrl_i       ( ctrl_i    ),
    .enable_i     ( gen_en    ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( wr_acc    ),
    .done_o       ( gen_done  )
  );

  // address joined with a beat, one word write
  assign mem_req_o.req   = gen_en & gen_valid & snk_strm_i.valid;
  assign mem_req_o.we    = 1'b1;
  assign mem_req_o.be    = 4'hf;
  assign mem_req_o.addr  = {gen_addr[streamer_pkg::ADDR_W-1:2], 2'b00};
  assign mem_req_o.wdata = snk_strm_i.data;

  assign snk_ready_o = gen_en & gen_valid & mem_rsp_i.gnt;  // no gnt, beat stays
  assign wr_acc      = mem_req_o.req & mem_rsp_i.gnt;
  assign wr_cnt_d    = wr_cnt_q + {{(streamer_pkg::LEN_W-1){1'b0}}, wr_acc};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs       <= streamer_pkg::IDLE;
      wr_cnt_q <= '0;
      len_q    <= '0;
    end else if (clear_i) begin
      cs       <= streamer_pkg::IDLE;
      wr_cnt_q <= '0;
    end else begin
      cs       <= ns;
      wr_cnt_q <= job_end ? '0 : wr_cnt_d;
      if (cs == streamer_pkg::IDLE && ctrl_i.start)
        len_q <= ctrl_i.length;
    end
  end

  always_comb begin
    ns                  = cs;
    job_end             = 1'b0;
    flags_o.ready_start = 1'b0;
    case (cs)
      streamer_pkg::IDLE: begin
        flags_o.ready_start = 1'b1;
        if (ctrl_i.start)
          ns = streamer_pkg::WORKING;
      end
      streamer_pkg::WORKING: begin
        if (wr_cnt_d == len_q)
          ns = streamer_pkg::DONE;  // last write granted now
      end
      streamer_pkg::DONE: begin
        if (gen_done && wr_cnt_q == len_q) begin
          job_end = 1'b1;
          ns      = streamer_pkg::IDLE;
        end
      end
      default: ns = streamer_pkg::IDLE;
    endcase
  end

  assign gen_en       = (cs == streamer_pkg::WORKING);
  assign gen_clr      = clear_i | job_end;
  assign flags_o.done = job_end;

endmodule

/* hdl/core_source.sv */
`timescale 1ns/1ns

module core_source (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  output streamer_pkg::streamer_flags_t flags_o,
  output streamer_pkg::mem_req_t        mem_req_o,
  input  streamer_pkg::mem_rsp_t        mem_rsp_i,
  output streamer_pkg::strm_t           src_strm_o,
  input  logic                          src_ready_i
);

  streamer_pkg::streamer_state_t cs, ns;

  logic                               gen_en;
  logic                               gen_clr;
  logic                               gen_valid;
  logic                               gen_ready;
  logic                               gen_done;
  logic [streamer_pkg::ADDR_W-1:0]    gen_addr;

  // address fifo, two slots, head in slot 0
  logic [streamer_pkg::ADDR_W-1:0]    af_q [2];
  logic [1:0]                         af_cnt_q;
  logic                               af_push;
  logic                               af_pop;
  logic                               af_valid;
  logic                               af_wr_idx;

  // offset fifo, addr[1:0] of each load in flight
  logic [1:0]                         offs_q [streamer_pkg::OFFS_DEPTH];
  logic [streamer_pkg::OFFS_PTR_W-1:0] offs_wr_q;
  logic [streamer_pkg::OFFS_PTR_W-1:0] offs_rd_q;
  logic [streamer_pkg::OFFS_PTR_W:0]  offs_cnt_q;
  logic                               offs_full;
  logic                               offs_push;
  logic                               offs_pop;

  logic                               req_pend_q;  // raised, not yet granted
  logic                               hold_valid_q;
  logic [streamer_pkg::MEM_W-1:0]     hold_data_q;
  logic [streamer_pkg::MEM_W-1:0]     win;
  logic                               strm_xfer;
  logic [streamer_pkg::LEN_W-1:0]     strm_cnt_q;
  logic [streamer_pkg::LEN_W-1:0]     len_q;
  logic                               job_end;

  stream_addr_gen i_addr_gen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .clear_i      ( gen_clr   ),
    .ctrl_i       ( ctrl_i    ),
    .enable_i     ( gen_en    ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( gen_ready ),
    .done_o       ( gen_done  )
  );

  assign gen_ready = (af_cnt_q != 2'd2);
  assign af_push   = gen_valid & gen_ready;
  assign af_valid  = (af_cnt_q != 2'd0);
  assign af_pop    = mem_req_o.req & mem_rsp_i.gnt;
  assign af_wr_idx = af_cnt_q[0] & ~af_pop;  // slot 1 only if head stays

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      af_cnt_q <= '0;
    else if (clear_i)
      af_cnt_q <= '0;
    else
      af_cnt_q <= af_cnt_q + {1'b0, af_push} - {1'b0, af_pop};
  end

  always_ff @(posedge clk_i) begin
    if (af_pop)
      af_q[0] <= af_q[1];        // shift toward head
    if (af_push)
      af_q[af_wr_idx] <= gen_addr;  // wins over the shift
  end

  // loads, no new one under back-pressure, a raised one stays until gnt
  assign mem_req_o.req   = (cs != streamer_pkg::IDLE) & af_valid &
                           ((src_ready_i & ~offs_full) | req_pend_q);
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.be    = '0;
  assign mem_req_o.addr  = {af_q[0][streamer_pkg::ADDR_W-1:2], 2'b00};
  assign mem_req_o.wdata = '0;

  assign offs_full = (offs_cnt_q == (streamer_pkg::OFFS_PTR_W+1)'(streamer_pkg::OFFS_DEPTH));
  assign offs_push = af_pop;
  assign offs_pop  = strm_xfer;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_pend_q <= 1'b0;
      offs_wr_q  <= '0;
      offs_rd_q  <= '0;
      offs_cnt_q <= '0;
    end else if (clear_i) begin
      req_pend_q <= 1'b0;
      offs_wr_q  <= '0;
      offs_rd_q  <= '0;
      offs_cnt_q <= '0;
    end else begin
      req_pend_q <= mem_req_o.req & ~mem_rsp_i.gnt;
      offs_wr_q  <= offs_wr_q + offs_push;  // wraps, depth is a power of two
      offs_rd_q  <= offs_rd_q + offs_pop;
      offs_cnt_q <= offs_cnt_q + offs_push - offs_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (offs_push)
      offs_q[offs_wr_q] <= af_q[0][1:0];
  end

  // hold register catches a response that meets ready low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      hold_valid_q <= 1'b0;
    else if (clear_i)
      hold_valid_q <= 1'b0;
    else if (mem_rsp_i.r_valid)
      hold_valid_q <= ~src_ready_i;
    else if (src_ready_i)
      hold_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.r_valid)
      hold_data_q <= mem_rsp_i.rdata;
  end

  // four bytes of the window from the head offset on
  assign win              = mem_rsp_i.r_valid ? mem_rsp_i.rdata : hold_data_q;
  assign src_strm_o.valid = mem_rsp_i.r_valid | hold_valid_q;
  assign src_strm_o.data  = win[{offs_q[offs_rd_q], 3'b000} +: streamer_pkg::STRM_W];
  assign strm_xfer        = src_strm_o.valid & src_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs         <= streamer_pkg::IDLE;
      strm_cnt_q <= '0;
      len_q      <= '0;
    end else if (clear_i) begin
      cs         <= streamer_pkg::IDLE;
      strm_cnt_q <= '0;
    end else begin
      cs <= ns;
      if (cs == streamer_pkg::IDLE && ctrl_i.start)
        len_q <= ctrl_i.length;   // own copy, ctrl may change mid job
      if (job_end)
        strm_cnt_q <= '0;
      else if (strm_xfer)
        strm_cnt_q <= strm_cnt_q + 1'b1;
    end
  end

  always_comb begin
    ns                  = cs;
    gen_en              = 1'b0;
    job_end             = 1'b0;
    flags_o.ready_start = 1'b0;
    case (cs)
      streamer_pkg::IDLE: begin
        flags_o.ready_start = 1'b1;
        if (ctrl_i.start)
          ns = streamer_pkg::WORKING;
      end
      streamer_pkg::WORKING: begin
        gen_en = 1'b1;
        if (gen_done)
          ns = streamer_pkg::DONE;  // all addresses in the fifo
      end
      streamer_pkg::DONE: begin
        if (!af_valid && strm_cnt_q == len_q) begin
          job_end = 1'b1;
          ns      = streamer_pkg::IDLE;
        end
      end
      default: ns = streamer_pkg::IDLE;
    endcase
  end

  assign gen_clr      = clear_i | job_end;
  assign flags_o.done = job_end;  // single cycle, IDLE follows

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  streamer_pkg::mem_req_t req_i [2],
  output streamer_pkg::mem_rsp_t rsp_o [2],
  output streamer_pkg::mem_req_t bank_req_o,
  input  streamer_pkg::mem_rsp_t bank_rsp_i
);

  logic both;
  logic sel;        // port that owns the bank this cycle
  logic prio_q;     // preferred port on conflict
  logic accept;
  logic rd_port_q;  // port of last granted read

  assign both       = req_i[0].req & req_i[1].req;
  assign sel        = both ? prio_q : req_i[1].req;
  assign bank_req_o = req_i[sel];
  assign accept     = bank_req_o.req & bank_rsp_i.gnt;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rsp_o[i].gnt     = accept & (sel == 1'(i));
      rsp_o[i].r_valid = bank_rsp_i.r_valid & (rd_port_q == 1'(i));
      rsp_o[i].rdata   = bank_rsp_i.rdata;  // shared, qualified by r_valid
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q    <= 1'b0;
      rd_port_q <= 1'b0;
    end else if (accept) begin
      prio_q <= ~sel;  // round robin, flips on every grant
      if (!bank_req_o.we)
        rd_port_q <= sel;
    end
  end

endmodule

/* hdl/stream_addr_gen.sv */
`timescale 1ns/1ns

module stream_addr_gen (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  streamer_pkg::streamer_ctrl_t       ctrl_i,
  input  logic                               enable_i,
  output logic [streamer_pkg::ADDR_W-1:0]    addr_o,
  output logic                               addr_valid_o,
  input  logic                               addr_ready_i,
  output logic                               done_o
);

  logic                               busy_q;    // job sampled, not yet cleared
  logic                               done_q;
  logic [streamer_pkg::LEN_W-1:0]     len_q;
  logic [streamer_pkg::LEN_W-1:0]     cnt_q;     // addresses handed out
  logic [streamer_pkg::LEN_W-1:0]     cnt_nxt;
  logic [streamer_pkg::ADDR_W-1:0]    addr_q;
  logic [streamer_pkg::STRIDE_W-1:0]  stride_q;
  logic                               sample;
  logic                               take;

  assign sample       = ctrl_i.start & ~busy_q;  // only between jobs
  assign addr_valid_o = enable_i & busy_q & (cnt_q != len_q);
  assign take         = addr_valid_o & addr_ready_i;
  assign cnt_nxt      = cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      len_q  <= '0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (sample) begin
      busy_q <= 1'b1;
      len_q  <= ctrl_i.length;
      cnt_q  <= '0;
      done_q <= (ctrl_i.length == '0);  // empty job finishes at once
    end else if (take) begin
      cnt_q <= cnt_nxt;
      if (cnt_nxt == len_q)
        done_q <= 1'b1;                 // visible the cycle after the last address
    end
  end

  // address datapath
  always_ff @(posedge clk_i) begin
    if (sample) begin
      addr_q   <= ctrl_i.base_addr;
      stride_q <= ctrl_i.stride;
    end else if (take) begin
      addr_q <= addr_q + streamer_pkg::ADDR_W'(stride_q);
    end
  end

  assign addr_o = addr_q;
  assign done_o = done_q;  // held until clear

endmodule

/* hdl/streamer_pkg.sv */
package streamer_pkg;

  // widths
  localparam int ADDR_W   = 32;  // byte address
  localparam int STRM_W   = 32;  // stream beat
  localparam int MEM_W    = 64;  // read window, one beat plus misalignment slack
  localparam int LEN_W    = 16;  // length and counters
  localparam int STRIDE_W = 16;  // stride in bytes

  // memory geometry
  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // offset fifo in the source, >= gnt to r_valid latency + 1
  localparam int OFFS_DEPTH = 4;
  localparam int OFFS_PTR_W = $clog2(OFFS_DEPTH);

  // one memory request, held stable until gnt
  typedef struct packed {
    logic              req;
    logic              we;     // 1 = store
    logic [3:0]        be;
    logic [ADDR_W-1:0] addr;   // word aligned
    logic [STRM_W-1:0] wdata;
  } mem_req_t;

  // response, r_valid one cycle after the accepting edge
  typedef struct packed {
    logic             gnt;
    logic             r_valid;
    logic [MEM_W-1:0] rdata;   // two words, lower index in low half
  } mem_rsp_t;

  // stream beat, ready runs the other way
  typedef struct packed {
    logic              valid;
    logic [STRM_W-1:0] data;
  } strm_t;

  // job setup
  typedef struct packed {
    logic                start;
    logic [ADDR_W-1:0]   base_addr;
    logic [STRIDE_W-1:0] stride;     // bytes
    logic [LEN_W-1:0]    length;     // words
  } streamer_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } streamer_flags_t;

  typedef enum logic [1:0] {
    IDLE,
    WORKING,
    DONE
  } streamer_state_t;

endpackage

/* hdl/streamer_top.sv */
`timescale 1ns/1ns

module streamer_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  streamer_pkg::streamer_ctrl_t  src_ctrl_i,
  output streamer_pkg::streamer_flags_t src_flags_o,
  input  streamer_pkg::streamer_ctrl_t  snk_ctrl_i,
  output streamer_pkg::streamer_flags_t snk_flags_o,
  output streamer_pkg::strm_t           src_strm_o,
  input  logic                          src_ready_i,
  input  streamer_pkg::strm_t           snk_strm_i,
  output logic                          snk_ready_o
);

  streamer_pkg::mem_req_t arb_req [2];  // 0 source, 1 sink
  streamer_pkg::mem_rsp_t arb_rsp [2];
  streamer_pkg::mem_req_t bank_req;
  streamer_pkg::mem_rsp_t bank_rsp;

  core_source i_source (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .ctrl_i      ( src_ctrl_i  ),
    .flags_o     ( src_flags_o ),
    .mem_req_o   ( arb_req[0]  ),
    .mem_rsp_i   ( arb_rsp[0]  ),
    .src_strm_o  ( src_strm_o  ),
    .src_ready_i ( src_ready_i )
  );

  core_sink i_sink (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .ctrl_i      ( snk_ctrl_i  ),
    .flags_o     ( snk_flags_o ),
    .mem_req_o   ( arb_req[1]  ),
    .mem_rsp_i   ( arb_rsp[1]  ),
    .snk_strm_i  ( snk_strm_i  ),
    .snk_ready_o ( snk_ready_o )
  );

  mem_arbiter i_arbiter (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .req_i      ( arb_req  ),
    .rsp_o      ( arb_rsp  ),
    .bank_req_o ( bank_req ),
    .bank_rsp_i ( bank_rsp )
  );

  tcdm_bank i_bank (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .req_i  ( bank_req ),
    .rsp_o  ( bank_rsp )
  );

endmodule

/* hdl/tcdm_bank.sv */
`timescale 1ns/1ns

module tcdm_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  streamer_pkg::mem_req_t req_i,
  output streamer_pkg::mem_rsp_t rsp_o
);

  logic [streamer_pkg::STRM_W-1:0]    mem_q [streamer_pkg::MEM_WORDS];
  logic [streamer_pkg::MEM_IDX_W-1:0] idx;
  logic [streamer_pkg::MEM_IDX_W-1:0] idx_nxt;  // wraps at the top
  logic [streamer_pkg::MEM_W-1:0]     rdata_q;
  logic                               r_valid_q;

  assign idx     = req_i.addr[streamer_pkg::MEM_IDX_W+1:2];
  assign idx_nxt = idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++)
          if (req_i.be[b])
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end else begin
        rdata_q <= {mem_q[idx_nxt], mem_q[idx]};  // two word window
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      r_valid_q <= 1'b0;
    else
      r_valid_q <= req_i.req & ~req_i.we;
  end

  assign rsp_o.gnt     = req_i.req;  // always grants
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.rdata   = rdata_q;

endmodule

/* project.f */
hdl/streamer_pkg.sv
hdl/stream_addr_gen.sv
hdl/core_source.sv
hdl/core_sink.sv
hdl/mem_arbiter.sv
hdl/tcdm_bank.sv
hdl/streamer_top.sv
verif/tb_clk_gen.sv
verif/streamer_asserts.sv
verif/streamer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the streamer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module streamer_tb -f project.f -o sim_streamer

./obj_dir/sim_streamer | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"

/* verif/streamer_asserts.sv */
`timescale 1ns/1ns

module streamer_asserts (
  input logic                                    clk_i,
  input logic                                    rst_ni,
  input streamer_pkg::streamer_state_t           state_i,
  input logic                                    req_i,
  input logic                                    done_i,
  input logic                                    valid_i,
  input logic [streamer_pkg::STRM_W-1:0]         data_i,
  input logic                                    ready_i,
  input logic [streamer_pkg::OFFS_PTR_W:0]       offs_cnt_i
);

  no_req_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> state_i != streamer_pkg::IDLE)
    else $error("memory request raised while the source is idle");

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("source done held for more than one cycle");

  // stalled beat keeps its data
  beat_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(data_i)))
    else $error("source beat changed while stalled");

  offs_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    offs_cnt_i <= (streamer_pkg::OFFS_PTR_W+1)'(streamer_pkg::OFFS_DEPTH))
    else $error("offset fifo overflow");

endmodule

bind core_source streamer_asserts i_asserts (
  .clk_i      ( clk_i              ),
  .rst_ni     ( rst_ni             ),
  .state_i    ( cs                 ),
  .req_i      ( mem_req_o.req      ),
  .done_i     ( flags_o.done       ),
  .valid_i    ( src_strm_o.valid   ),
  .data_i     ( src_strm_o.data    ),
  .ready_i    ( src_ready_i        ),
  .offs_cnt_i ( offs_cnt_q         )
);

/* verif/streamer_tb.sv */
`timescale 1ns/1ns

module streamer_tb;

  localparam int TD_DEPTH = 256;   // words in the job file
  localparam int DRV_NS   = 10;    // drive skew after the rising edge
  localparam int BYTES    = streamer_pkg::MEM_WORDS * 4;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          clear_i;
  streamer_pkg::streamer_ctrl_t  src_ctrl;
  streamer_pkg::streamer_ctrl_t  snk_ctrl;
  streamer_pkg::streamer_flags_t src_flags;
  streamer_pkg::streamer_flags_t snk_flags;
  streamer_pkg::strm_t           src_strm;
  streamer_pkg::strm_t           snk_strm;
  logic                          src_ready;
  logic                          snk_ready;

  logic [31:0] tdata  [TD_DEPTH];
  logic [7:0]  shadow [BYTES];     // byte model of the bank
  logic [31:0] rd_exp [64];        // expected beats of the current read
  integer      seed;
  int          errors;
  int          checks;
  int          limit_cycles;
  logic        limit_set;

  tb_clk_gen i_clk (.clk_o(clk_i));

  streamer_top dut (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( clear_i   ),
    .src_ctrl_i  ( src_ctrl  ),
    .src_flags_o ( src_flags ),
    .snk_ctrl_i  ( snk_ctrl  ),
    .snk_flags_o ( snk_flags ),
    .src_strm_o  ( src_strm  ),
    .src_ready_i ( src_ready ),
    .snk_strm_i  ( snk_strm  ),
    .snk_ready_o ( snk_ready )
  );

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
    end
  endtask

  // four bytes from A on as in the two word window
  function automatic logic [31:0] window_word(input logic [31:0] a);
    logic [31:0] w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = shadow[int'((a + 32'(k)) % 32'(BYTES))];
    return w;
  endfunction

  task automatic apply_write(input logic [31:0] base, input logic [15:0] stride,
                             input int len, input int p);
    logic [31:0] a;
    for (int i = 0; i < len; i++) begin
      a = ((base + 32'(i) * 32'(stride)) & ~32'h3) % 32'(BYTES);  // word aligned
      for (int k = 0; k < 4; k++)
        shadow[int'(a) + k] = tdata[p + i][8*k +: 8];
    end
  endtask

  // model expectation must agree with the file
  task automatic prep_read(input logic [31:0] base, input logic [15:0] stride,
                           input int len, input int p);
    for (int i = 0; i < len; i++) begin
      rd_exp[i] = window_word(base + 32'(i) * 32'(stride));
      check_value("testdata_vs_model", tdata[p + i], rd_exp[i]);
    end
  endtask

  task automatic run_source(input logic [31:0] base, input logic [15:0] stride,
                            input int len, input bit rand_ready);
    int cnt;
    int dones;
    cnt   = 0;
    dones = 0;
    @(posedge clk_i);
    #DRV_NS;
    src_ctrl.start     = 1'b1;
    src_ctrl.base_addr = base;
    src_ctrl.stride    = stride;
    src_ctrl.length    = 16'(len);
    src_ready          = 1'b1;
    while (dones == 0) begin
      @(negedge clk_i);  // inputs settled
      if (src_strm.valid && src_ready) begin
        if (cnt < len)
          check_value("src_strm.data", rd_exp[cnt], src_strm.data);
        cnt++;
      end
      if (src_flags.done)
        dones++;
      @(posedge clk_i);
      #DRV_NS;
      src_ctrl.start = 1'b0;
      src_ready      = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end
    @(posedge clk_i);
    #DRV_NS;
    src_ready = 1'b1;
    check_value("src_beat_count", 32'(len), 32'(cnt));
    // idle again with no stray beats or done
    repeat (3) begin
      @(negedge clk_i);
      check_value("src_flags.ready_start", 32'd1, 32'(src_flags.ready_start));
      check_value("src_strm.valid", 32'd0, 32'(src_strm.valid));
      check_value("src_flags.done", 32'd0, 32'(src_flags.done));
    end
  endtask

  task automatic run_sink(input logic [31:0] base, input logic [15:0] stride,
                          input int len, input int p);
    int   idx;
    int   dones;
    logic xfer;
    idx   = 0;
    dones = 0;
    @(posedge clk_i);
    #DRV_NS;
    snk_ctrl.start     = 1'b1;
    snk_ctrl.base_addr = base;
    snk_ctrl.stride    = stride;
    snk_ctrl.length    = 16'(len);
    snk_strm.valid     = 1'b0;
    while (dones == 0) begin
      @(negedge clk_i);
      xfer = snk_strm.valid & snk_ready;
      if (xfer)
        idx++;
      if (snk_flags.done)
        dones++;
      @(posedge clk_i);
      #DRV_NS;
      snk_ctrl.start = 1'b0;
      if (!snk_strm.valid || xfer) begin   // a pending beat stays put
        snk_strm.valid = (idx < len) && (($random(seed) & 3) != 0);
        snk_strm.data  = (idx < len) ? tdata[p + idx] : 32'h0;
      end
    end
    @(posedge clk_i);
    #DRV_NS;
    snk_strm.valid = 1'b1;  // beat offered to an idle sink
    check_value("snk_beat_count", 32'(len), 32'(idx));
    @(negedge clk_i);
    check_value("snk_flags.ready_start", 32'd1, 32'(snk_flags.ready_start));
    check_value("snk_flags.done", 32'd0, 32'(snk_flags.done));
    check_value("snk_ready", 32'd0, 32'(snk_ready));
    @(posedge clk_i);
    #DRV_NS;
    snk_strm.valid = 1'b0;
  endtask

  initial begin
    int p;
    int q;
    int total;
    seed      = 99;
    errors    = 0;
    checks    = 0;
    limit_set = 1'b0;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    src_ctrl  = '0;
    snk_ctrl  = '0;
    snk_strm  = '0;
    src_ready = 1'b1;
    $readmemh("verif/streamer_testdata.txt", tdata);
    p     = 0;
    total = 0;
    while (p < TD_DEPTH && tdata[p] != 32'h0) begin  // count words for the watchdog
      total += int'(tdata[p+3]);
      p     += 4 + int'(tdata[p+3]);
    end
    limit_cycles = total * 40 + 200;
    limit_set    = 1'b1;
    repeat (2) @(posedge clk_i);
    #DRV_NS;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("src_flags.ready_start", 32'd1, 32'(src_flags.ready_start));
    check_value("snk_flags.ready_start", 32'd1, 32'(snk_flags.ready_start));
    check_value("src_strm.valid", 32'd0, 32'(src_strm.valid));
    p = 0;
    while (p < TD_DEPTH && tdata[p] != 32'h0) begin
      case (tdata[p])
        32'd1: begin
          apply_write(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), p + 4);
          run_sink(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), p + 4);
          p += 4 + int'(tdata[p+3]);
        end
        32'd2: begin
          prep_read(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), p + 4);
          run_source(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), 1'b1);
          p += 4 + int'(tdata[p+3]);
        end
        32'd3: begin  // write and the next read run together
          q = p + 4 + int'(tdata[p+3]);
          apply_write(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), p + 4);
          prep_read(tdata[q+1], tdata[q+2][15:0], int'(tdata[q+3]), q + 4);
          fork
            run_sink(tdata[p+1], tdata[p+2][15:0], int'(tdata[p+3]), p + 4);
            run_source(tdata[q+1], tdata[q+2][15:0], int'(tdata[q+3]), 1'b0);
          join
          p = q + 4 + int'(tdata[q+3]);
        end
        default: begin
          errors++;
          $display("unknown job kind %0h in the job file at word %0d", tdata[p], p);
          p = TD_DEPTH;
        end
      endcase
    end
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog scaled by the job sizes
  initial begin
    wait (limit_set);
    repeat (limit_cycles) @(posedge clk_i);
    $display("timeout after %0d cycles, a job never signalled done", limit_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* verif/streamer_testdata.txt */
// kind base stride length, then length data words (hex)
// kind 1 write, 2 read, 3 write run alongside the next read, 0 end
1 00000000 0004 0008
03020100 07060504 0b0a0908 0f0e0d0c 13121110 17161514 1b1a1918 1f1e1d1c
2 00000000 0004 0008
03020100 07060504 0b0a0908 0f0e0d0c 13121110 17161514 1b1a1918 1f1e1d1c
2 00000001 0004 0003
04030201 08070605 0c0b0a09
2 00000002 0008 0002
05040302 0d0c0b0a
2 00000003 0004 0002
06050403 0a090807
1 00000004 000c 0002
aaaa0001 aaaa0002
2 00000000 0004 0006
03020100 aaaa0001 0b0a0908 0f0e0d0c aaaa0002 17161514
2 00000004 000c 0002
aaaa0001 aaaa0002
3 00000100 0004 0004
c0de0000 c0de0001 c0de0002 c0de0003
2 00000015 0004 0002
18171615 1c1b1a19
2 00000100 0004 0004
c0de0000 c0de0001 c0de0002 c0de0003
0

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o
);

  localparam int HALF_NS = 50;  // 100 ns period

  initial clk_o = 1'b0;
  always #HALF_NS clk_o = ~clk_o;

endmodule
